/* compile.f */
logic/reg_grp_pkg.sv
logic/counter_ram.sv
logic/update_sequencer.sv
logic/update_merge.sv
logic/port_arbiter.sv
logic/oq_stat_reg_grp.sv
sim/oq_stat_reg_grp_props.sv
sim/tb_oq_stat_reg_grp.sv

/* logic/counter_ram.sv */
// Dual-port counter memory for all queues with registered read data
`timescale 1ns/1ps

module counter_ram
   import reg_grp_pkg::*;
(
   input  logic        clk,

   // Port A
   input  queue_addr_t addr_a,
   input  logic        we_a,
   input  reg_value_t  din_a,
   output reg_value_t  dout_a,

   // Port B
   input  queue_addr_t addr_b,
   input  logic        we_b,
   input  reg_value_t  din_b,
   output reg_value_t  dout_b
);

   // One counter per queue
   reg_value_t mem [NUM_QUEUES];

   // Reads return the old value on a same-cycle write
   always_ff @(posedge clk) begin
      if (we_a) begin
         mem[addr_a] <= din_a;
      end
      if (we_b) begin
         mem[addr_b] <= din_b;
      end
      dout_a <= mem[addr_a];
      dout_b <= mem[addr_b];
   end

endmodule

/* logic/oq_stat_reg_grp.sv */
// Per-queue statistics counters with two add-update channels and host access
`timescale 1ns/1ps

module oq_stat_reg_grp
   import reg_grp_pkg::*;
(
   input  logic         clk,
   input  logic         reset,

   // Channel A
   input  logic         rd_a,
   input  queue_addr_t  rd_addr_a,
   output reg_value_t   rd_data_a,
   input  logic         wr_a,
   input  queue_addr_t  wr_addr_a,
   input  write_value_t wr_data_a,
   output logic         wr_done_a,
   output reg_value_t   wr_new_value_a,

   // Channel B
   input  logic         rd_b,
   input  queue_addr_t  rd_addr_b,
   output reg_value_t   rd_data_b,
   input  logic         wr_b,
   input  queue_addr_t  wr_addr_b,
   input  write_value_t wr_data_b,
   output logic         wr_done_b,
   output reg_value_t   wr_new_value_b,

   // Host request and acknowledge
   input  logic         reg_req,
   input  logic         reg_wr,
   input  queue_addr_t  reg_addr,
   input  reg_value_t   reg_wr_data,
   output logic         reg_ack,
   output reg_value_t   reg_rd_data
);

   // --------------------------------------------------
   // Internal signals
   // --------------------------------------------------

   // A read on either channel pauses all writes
   logic         rd_any;

   // Sequencer requests toward the arbiter
   logic         want_read_a;
   logic         want_read_b;
   queue_addr_t  read_addr_a;
   queue_addr_t  read_addr_b;
   logic         want_write_a;
   logic         want_write_b;
   queue_addr_t  write_addr_a;
   queue_addr_t  write_addr_b;
   reg_value_t   write_value_a;
   reg_value_t   write_value_b;
   logic         held_wr_a;
   logic         held_wr_b;
   write_value_t held_amount_a;
   write_value_t held_amount_b;

   // Current values back from the arbiter
   reg_value_t   curr_value_a;
   reg_value_t   curr_value_b;

   // Joint update of both channels
   logic         merge_active;
   joint_value_t merge_amount;

   // RAM ports
   queue_addr_t  ram_addr_a;
   queue_addr_t  ram_addr_b;
   logic         ram_we_a;
   logic         ram_we_b;
   reg_value_t   ram_din_a;
   reg_value_t   ram_din_b;
   reg_value_t   ram_dout_a;
   reg_value_t   ram_dout_b;

   assign rd_any = rd_a | rd_b;

   // --------------------------------------------------
   // Channel sequencers
   // --------------------------------------------------

   // Channel A takes the merged amount and never cancels
   update_sequencer u_seq_a (
      .clk          (clk),
      .reset        (reset),
      .wr           (wr_a),
      .wr_addr      (wr_addr_a),
      .wr_data      (wr_data_a),
      .rd           (rd_a),
      .rd_addr      (rd_addr_a),
      .rd_any       (rd_any),
      .curr_value   (curr_value_a),
      .merge_amount (merge_amount),
      .merge_active (merge_active),
      .merge_cancel (1'b0),
      .want_read    (want_read_a),
      .read_addr    (read_addr_a),
      .want_write   (want_write_a),
      .write_addr   (write_addr_a),
      .write_value  (write_value_a),
      .held_wr      (held_wr_a),
      .held_amount  (held_amount_a)
   );

   // Channel B drops its write-back when merged into A
   update_sequencer u_seq_b (
      .clk          (clk),
      .reset        (reset),
      .wr           (wr_b),
      .wr_addr      (wr_addr_b),
      .wr_data      (wr_data_b),
      .rd           (rd_b),
      .rd_addr      (rd_addr_b),
      .rd_any       (rd_any),
      .curr_value   (curr_value_b),
      .merge_amount ('0),
      .merge_active (1'b0),
      .merge_cancel (merge_active),
      .want_read    (want_read_b),
      .read_addr    (read_addr_b),
      .want_write   (want_write_b),
      .write_addr   (write_addr_b),
      .write_value  (write_value_b),
      .held_wr      (held_wr_b),
      .held_amount  (held_amount_b)
   );

   update_merge u_merge (
      .clk           (clk),
      .reset         (reset),
      .rd_any        (rd_any),
      .wr_a          (wr_a),
      .wr_b          (wr_b),
      .held_wr_a     (held_wr_a),
      .held_wr_b     (held_wr_b),
      .wr_data_a     (wr_data_a),
      .wr_data_b     (wr_data_b),
      .held_amount_a (held_amount_a),
      .held_amount_b (held_amount_b),
      .read_addr_a   (read_addr_a),
      .read_addr_b   (read_addr_b),
      .merge_active  (merge_active),
      .merge_amount  (merge_amount)
   );

   // --------------------------------------------------
   // Port control and storage
   // --------------------------------------------------

   port_arbiter u_arbiter (
      .clk            (clk),
      .reset          (reset),
      .rd_any         (rd_any),
      .want_read_a    (want_read_a),
      .read_addr_a    (read_addr_a),
      .want_write_a   (want_write_a),
      .write_addr_a   (write_addr_a),
      .write_value_a  (write_value_a),
      .wr_a           (wr_a),
      .held_wr_a      (held_wr_a),
      .want_read_b    (want_read_b),
      .read_addr_b    (read_addr_b),
      .want_write_b   (want_write_b),
      .write_addr_b   (write_addr_b),
      .write_value_b  (write_value_b),
      .wr_b           (wr_b),
      .held_wr_b      (held_wr_b),
      .reg_req        (reg_req),
      .reg_wr         (reg_wr),
      .reg_addr       (reg_addr),
      .reg_wr_data    (reg_wr_data),
      .ram_addr_a     (ram_addr_a),
      .ram_addr_b     (ram_addr_b),
      .ram_we_a       (ram_we_a),
      .ram_we_b       (ram_we_b),
      .ram_din_a      (ram_din_a),
      .ram_din_b      (ram_din_b),
      .ram_dout_a     (ram_dout_a),
      .ram_dout_b     (ram_dout_b),
      .curr_value_a   (curr_value_a),
      .curr_value_b   (curr_value_b),
      .rd_data_a      (rd_data_a),
      .rd_data_b      (rd_data_b),
      .wr_done_a      (wr_done_a),
      .wr_done_b      (wr_done_b),
      .wr_new_value_a (wr_new_value_a),
      .wr_new_value_b (wr_new_value_b),
      .reg_ack        (reg_ack),
      .reg_rd_data    (reg_rd_data)
   );

   counter_ram u_ram (
      .clk    (clk),
      .addr_a (ram_addr_a),
      .we_a   (ram_we_a),
      .din_a  (ram_din_a),
      .dout_a (ram_dout_a),
      .addr_b (ram_addr_b),
      .we_b   (ram_we_b),
      .din_b  (ram_din_b),
      .dout_b (ram_dout_b)
   );

endmodule

/* logic/port_arbiter.sv */
// Drives both RAM ports, forwards written values and serves the host on port A
`timescale 1ns/1ps

module port_arbiter
   import reg_grp_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        rd_any,

   // Channel A sequencer
   input  logic        want_read_a,
   input  queue_addr_t read_addr_a,
   input  logic        want_write_a,
   input  queue_addr_t write_addr_a,
   input  reg_value_t  write_value_a,
   input  logic        wr_a,
   input  logic        held_wr_a,

   // Channel B sequencer
   input  logic        want_read_b,
   input  queue_addr_t read_addr_b,
   input  logic        want_write_b,
   input  queue_addr_t write_addr_b,
   input  reg_value_t  write_value_b,
   input  logic        wr_b,
   input  logic        held_wr_b,

   // Host request
   input  logic        reg_req,
   input  logic        reg_wr,
   input  queue_addr_t reg_addr,
   input  reg_value_t  reg_wr_data,

   // RAM ports
   output queue_addr_t ram_addr_a,
   output queue_addr_t ram_addr_b,
   output logic        ram_we_a,
   output logic        ram_we_b,
   output reg_value_t  ram_din_a,
   output reg_value_t  ram_din_b,
   input  reg_value_t  ram_dout_a,
   input  reg_value_t  ram_dout_b,

   // Back to the sequencers
   output reg_value_t  curr_value_a,
   output reg_value_t  curr_value_b,

   // Channel and host results
   output reg_value_t  rd_data_a,
   output reg_value_t  rd_data_b,
   output logic        wr_done_a,
   output logic        wr_done_b,
   output reg_value_t  wr_new_value_a,
   output reg_value_t  wr_new_value_b,
   output logic        reg_ack,
   output reg_value_t  reg_rd_data
);

   ram_op_e    op_a;
   ram_op_e    op_b;

   // Last cycle's write data and forwarding flags
   reg_value_t prev_din_a;
   reg_value_t prev_din_b;
   logic       bypass_a;
   logic       bypass_b;

   // --------------------------------------------------
   // Operation choice
   // --------------------------------------------------

   // Reads first, then write-back, host only when port B is not writing
   always_comb begin
      op_a = RAM_IDLE;
      if (want_read_a) begin
         op_a = RAM_READ;
      end else if (want_write_a) begin
         op_a = RAM_WRITE;
      end else if (reg_req && !reg_ack && !want_write_b) begin
         // reg_req is still high in the ack cycle
         op_a = RAM_HOST;
      end
   end

   always_comb begin
      op_b = RAM_IDLE;
      if (want_read_b) begin
         op_b = RAM_READ;
      end else if (want_write_b) begin
         op_b = RAM_WRITE;
      end
   end

   // --------------------------------------------------
   // RAM drive
   // --------------------------------------------------

   always_comb begin
      ram_addr_a = read_addr_a;
      ram_we_a   = 1'b0;
      ram_din_a  = write_value_a;
      case (op_a)
         RAM_WRITE: begin
            ram_addr_a = write_addr_a;
            ram_we_a   = 1'b1;
         end
         RAM_HOST: begin
            ram_addr_a = reg_addr;
            ram_we_a   = reg_wr;
            ram_din_a  = reg_wr_data;
         end
         default: begin
            ram_addr_a = read_addr_a;
         end
      endcase
   end

   // No host path on port B
   assign ram_addr_b = (op_b == RAM_WRITE) ? write_addr_b : read_addr_b;
   assign ram_we_b   = (op_b == RAM_WRITE);
   assign ram_din_b  = write_value_b;

   // --------------------------------------------------
   // Forwarding between ports
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      prev_din_a <= ram_din_a;
      prev_din_b <= ram_din_b;
   end

   // Prep read of a queue the other port writes in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         bypass_a <= 1'b0;
         bypass_b <= 1'b0;
      end else begin
         bypass_a <= (wr_a | held_wr_a) && !rd_any && ram_we_b &&
                     (ram_addr_a == ram_addr_b);
         bypass_b <= (wr_b | held_wr_b) && !rd_any && ram_we_a &&
                     (ram_addr_b == ram_addr_a);
      end
   end

   assign curr_value_a = bypass_a ? prev_din_b : ram_dout_a;
   assign curr_value_b = bypass_b ? prev_din_a : ram_dout_b;

   // --------------------------------------------------
   // Results
   // --------------------------------------------------

   // Read data straight from the RAM register
   assign rd_data_a   = ram_dout_a;
   assign rd_data_b   = ram_dout_b;
   assign reg_rd_data = ram_dout_a;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_done_a <= 1'b0;
         wr_done_b <= 1'b0;
         reg_ack   <= 1'b0;
      end else begin
         wr_done_a <= (op_a == RAM_WRITE);
         wr_done_b <= (op_b == RAM_WRITE);
         reg_ack   <= (op_a == RAM_HOST);
      end
   end

   // New counter value beside its done pulse
   always_ff @(posedge clk) begin
      wr_new_value_a <= ram_din_a;
      wr_new_value_b <= ram_din_b;
   end

endmodule

/* logic/reg_grp_pkg.sv */
// Shared sizes, value types and encodings for the queue statistics register group
package reg_grp_pkg;

   // --------------------------------------------------
   // Sizes
   // --------------------------------------------------

   // One counter per output queue
   localparam int NUM_QUEUES       = 8;
   localparam int QUEUE_ADDR_WIDTH = 3;

   // Counter and update amount widths
   localparam int REG_WIDTH        = 32;
   localparam int WRITE_WIDTH      = 16;

   // --------------------------------------------------
   // Value types
   // --------------------------------------------------

   typedef logic [QUEUE_ADDR_WIDTH-1:0] queue_addr_t;
   typedef logic [REG_WIDTH-1:0]        reg_value_t;
   typedef logic [WRITE_WIDTH-1:0]      write_value_t;

   // Sum of two update amounts, one extra bit for the carry
   typedef logic [WRITE_WIDTH:0]        joint_value_t;

   // --------------------------------------------------
   // Encodings
   // --------------------------------------------------

   // Progress of one channel's add-update
   typedef enum logic [1:0] {
      UPD_IDLE    = 2'd0,   // Nothing pending
      UPD_HELD    = 2'd1,   // Request waits behind a read
      UPD_UPDATE  = 2'd2,   // Write-back cycle
      UPD_DELAYED = 2'd3    // Write-back pushed out by a read
   } upd_state_e;

   // What a RAM port does this cycle
   typedef enum logic [1:0] {
      RAM_IDLE  = 2'd0,
      RAM_READ  = 2'd1,
      RAM_WRITE = 2'd2,
      RAM_HOST  = 2'd3
   } ram_op_e;

endpackage

/* logic/update_merge.sv */
// Joins same-cycle updates of one queue from both channels into one amount
`timescale 1ns/1ps

module update_merge
   import reg_grp_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         rd_any,
   input  logic         wr_a,
   input  logic         wr_b,
   input  logic         held_wr_a,
   input  logic         held_wr_b,
   input  write_value_t wr_data_a,
   input  write_value_t wr_data_b,
   input  write_value_t held_amount_a,
   input  write_value_t held_amount_b,
   input  queue_addr_t  read_addr_a,
   input  queue_addr_t  read_addr_b,
   output logic         merge_active,
   output joint_value_t merge_amount
);

   write_value_t amount_a;
   write_value_t amount_b;
   joint_value_t joint_amount;
   logic         merge_start;

   // Amount of the update being prepared on each channel
   assign amount_a = held_wr_a ? held_amount_a : wr_data_a;
   assign amount_b = held_wr_b ? held_amount_b : wr_data_b;

   // Carry lands in the top bit
   assign joint_amount = joint_value_t'(amount_a) + joint_value_t'(amount_b);

   // Both channels run their prep read to one queue in this cycle
   assign merge_start = !rd_any && (wr_a | held_wr_a) && (wr_b | held_wr_b) &&
                        (read_addr_a == read_addr_b);

   always_ff @(posedge clk) begin
      if (reset) begin
         merge_active <= 1'b0;
      end else if (merge_start) begin
         merge_active <= 1'b1;
      end else begin
         // Stays up through every delayed write-back cycle
         merge_active <= merge_active & rd_any;
      end
   end

   always_ff @(posedge clk) begin
      if (merge_start) begin
         merge_amount <= joint_amount;
      end
   end

endmodule

/* logic/update_sequencer.sv */
// Tracks one channel's pending add-update and forms its write-back value
`timescale 1ns/1ps

module update_sequencer
   import reg_grp_pkg::*;
(
   input  logic         clk,
   input  logic         reset,

   // Channel requests
   input  logic         wr,
   input  queue_addr_t  wr_addr,
   input  write_value_t wr_data,
   input  logic         rd,
   input  queue_addr_t  rd_addr,
   input  logic         rd_any,

   // Value of the prepared queue, one cycle after its read
   input  reg_value_t   curr_value,

   // Joint amount and write-back cancel
   input  joint_value_t merge_amount,
   input  logic         merge_active,
   input  logic         merge_cancel,

   // Requests toward the port arbiter
   output logic         want_read,
   output queue_addr_t  read_addr,
   output logic         want_write,
   output queue_addr_t  write_addr,
   output reg_value_t   write_value,
   output logic         held_wr,
   output write_value_t held_amount
);

   upd_state_e  state;
   upd_state_e  state_nxt;

   // Request captured on arrival
   queue_addr_t held_addr;

   // Amount to add, zero extended
   reg_value_t  add_amount;
   reg_value_t  curr_plus_new;

   // Sum kept while a read pushes out the write-back
   reg_value_t  sum_d1;

   // --------------------------------------------------
   // Next state
   // --------------------------------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         UPD_IDLE: begin
            // Prep read only goes out when no read is pending
            if (wr) begin
               state_nxt = rd_any ? UPD_HELD : UPD_UPDATE;
            end
         end
         UPD_HELD: begin
            if (!rd_any) begin
               state_nxt = UPD_UPDATE;
            end
         end
         UPD_UPDATE: begin
            state_nxt = rd_any ? UPD_DELAYED : UPD_IDLE;
         end
         UPD_DELAYED: begin
            if (!rd_any) begin
               state_nxt = UPD_IDLE;
            end
         end
         default: begin
            state_nxt = UPD_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= UPD_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Address and amount of the new request
   always_ff @(posedge clk) begin
      if (wr) begin
         held_addr   <= wr_addr;
         held_amount <= wr_data;
      end
   end

   // First delayed cycle keeps the sum, RAM output moves on after that
   always_ff @(posedge clk) begin
      if (state == UPD_UPDATE && rd_any) begin
         sum_d1 <= curr_plus_new;
      end
   end

   // --------------------------------------------------
   // Requests
   // --------------------------------------------------

   assign held_wr = (state == UPD_HELD);

   // Reads win, otherwise read the queue to prepare the add
   assign want_read = rd_any | wr | held_wr;
   assign read_addr = rd ? rd_addr : (held_wr ? held_addr : wr_addr);

   // Merged amount replaces the channel's own one
   assign add_amount    = merge_active ? reg_value_t'(merge_amount) :
                                         reg_value_t'(held_amount);
   assign curr_plus_new = curr_value + add_amount;

   // No write-back while any read is in flight or when merged away
   assign want_write  = (state == UPD_UPDATE || state == UPD_DELAYED) &&
                        !rd_any && !merge_cancel;
   assign write_addr  = held_addr;
   assign write_value = (state == UPD_DELAYED) ? sum_d1 : curr_plus_new;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the register group testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module tb_oq_stat_reg_grp \
   -Mdir "$BUILD" -o tb_oq_stat_reg_grp -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD/tb_oq_stat_reg_grp" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
   exit 1
fi
exit 0

/* sim/oq_stat_reg_grp_props.sv */
// Protocol assertions on the host handshake and completion pulses of the register group
`timescale 1ns/1ps

module oq_stat_reg_grp_props (
   input logic clk,
   input logic reset,
   input logic reg_ack,
   input logic want_read_a,
   input logic want_write_a,
   input logic wr_done_a,
   input logic wr_done_b
);

   // --------------------------------------------------
   // Host handshake
   // --------------------------------------------------

   // Acknowledge is a single pulse
   ack_one_cycle: assert property (
      @(posedge clk) disable iff (reset) reg_ack |=> !reg_ack
   ) else $error("reg_ack stayed high for more than one cycle");

   // Host only gets port A when no channel uses it
   ack_port_free: assert property (
      @(posedge clk) disable iff (reset) (want_read_a || want_write_a) |=> !reg_ack
   ) else $error("reg_ack after a cycle with a channel access on port A");

   // --------------------------------------------------
   // Reset
   // --------------------------------------------------

   // No completion straight out of reset
   done_after_reset: assert property (
      @(posedge clk) reset |=> (!wr_done_a && !wr_done_b)
   ) else $error("update completion in the cycle after reset");

endmodule

/* sim/tb_oq_stat_reg_grp.sv */
// Testbench for the queue statistics register group with a reference counter model
`timescale 1ns/1ps

module tb_oq_stat_reg_grp
   import reg_grp_pkg::*;
();

   localparam int TIMEOUT = 64;

   logic         clk;
   logic         reset;
   logic         rd_a;
   logic         rd_b;
   queue_addr_t  rd_addr_a;
   queue_addr_t  rd_addr_b;
   reg_value_t   rd_data_a;
   reg_value_t   rd_data_b;
   logic         wr_a;
   logic         wr_b;
   queue_addr_t  wr_addr_a;
   queue_addr_t  wr_addr_b;
   write_value_t wr_data_a;
   write_value_t wr_data_b;
   logic         wr_done_a;
   logic         wr_done_b;
   reg_value_t   wr_new_value_a;
   reg_value_t   wr_new_value_b;
   logic         reg_req;
   logic         reg_wr;
   queue_addr_t  reg_addr;
   reg_value_t   reg_wr_data;
   logic         reg_ack;
   reg_value_t   reg_rd_data;

   // Reference counters and expected results in issue order
   reg_value_t   ref_mem [NUM_QUEUES];
   reg_value_t   exp_a[$];
   reg_value_t   exp_b[$];
   reg_value_t   rd_exp_a[$];
   reg_value_t   rd_exp_b[$];

   // Channel reads seen by the DUT at the last rising edge
   logic         rd_seen_a = 1'b0;
   logic         rd_seen_b = 1'b0;

   int           seed;

   oq_stat_reg_grp u_oq_stat_reg_grp (
      .clk            (clk),
      .reset          (reset),
      .rd_a           (rd_a),
      .rd_addr_a      (rd_addr_a),
      .rd_data_a      (rd_data_a),
      .wr_a           (wr_a),
      .wr_addr_a      (wr_addr_a),
      .wr_data_a      (wr_data_a),
      .wr_done_a      (wr_done_a),
      .wr_new_value_a (wr_new_value_a),
      .rd_b           (rd_b),
      .rd_addr_b      (rd_addr_b),
      .rd_data_b      (rd_data_b),
      .wr_b           (wr_b),
      .wr_addr_b      (wr_addr_b),
      .wr_data_b      (wr_data_b),
      .wr_done_b      (wr_done_b),
      .wr_new_value_b (wr_new_value_b),
      .reg_req        (reg_req),
      .reg_wr         (reg_wr),
      .reg_addr       (reg_addr),
      .reg_wr_data    (reg_wr_data),
      .reg_ack        (reg_ack),
      .reg_rd_data    (reg_rd_data)
   );

   // Protocol checks on the top level
   bind oq_stat_reg_grp oq_stat_reg_grp_props u_props (
      .clk          (clk),
      .reset        (reset),
      .reg_ack      (reg_ack),
      .want_read_a  (want_read_a),
      .want_write_a (want_write_a),
      .wr_done_a    (wr_done_a),
      .wr_done_b    (wr_done_b)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // --------------------------------------------------
   // Reference model and checking
   // --------------------------------------------------

   // Amounts are zero extended, the sum wraps at counter width
   function automatic reg_value_t add_ref(input reg_value_t old, input write_value_t amt_a,
                                          input write_value_t amt_b);
      return old + {16'h0, amt_a} + {16'h0, amt_b};
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_value(input string what, input reg_value_t actual,
                              input reg_value_t expected);
      if (actual !== expected) begin
         stop_run($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                            $time, what, actual, expected));
      end
   endtask

   always @(posedge clk) begin
      rd_seen_a <= rd_a;
      rd_seen_b <= rd_b;
   end

   // Outputs are settled by the falling edge
   always @(negedge clk) begin
      if (wr_done_a) begin
         if (exp_a.size() == 0) begin
            stop_run("Update completion on channel A with no update pending");
         end else begin
            check_value("wr_new_value_a", wr_new_value_a, exp_a.pop_front());
         end
      end
      if (wr_done_b) begin
         if (exp_b.size() == 0) begin
            stop_run("Update completion on channel B with no update pending");
         end else begin
            check_value("wr_new_value_b", wr_new_value_b, exp_b.pop_front());
         end
      end
      if (rd_seen_a) begin
         if (rd_exp_a.size() == 0) begin
            stop_run("Read on channel A with no expected value recorded");
         end else begin
            check_value("rd_data_a", rd_data_a, rd_exp_a.pop_front());
         end
      end
      if (rd_seen_b) begin
         if (rd_exp_b.size() == 0) begin
            stop_run("Read on channel B with no expected value recorded");
         end else begin
            check_value("rd_data_b", rd_data_b, rd_exp_b.pop_front());
         end
      end
   end

   // --------------------------------------------------
   // Stimulus tasks
   // --------------------------------------------------

   // reg_req stays up until reg_ack
   task automatic host_access(input logic write, input queue_addr_t addr,
                              input reg_value_t wdata, output reg_value_t rdata);
      int  n;
      logic got;
      n   = 0;
      got = 1'b0;
      @(negedge clk);
      reg_req     = 1'b1;
      reg_wr      = write;
      reg_addr    = addr;
      reg_wr_data = wdata;
      while (!got && n < TIMEOUT) begin
         @(negedge clk);
         n++;
         got = reg_ack;
      end
      if (!got) begin
         stop_run("Timed out waiting for reg_ack from the host port");
      end
      rdata   = reg_rd_data;
      reg_req = 1'b0;
      reg_wr  = 1'b0;
   endtask

   task automatic set_counter(input queue_addr_t q, input reg_value_t value);
      reg_value_t unused;
      host_access(1'b1, q, value, unused);
      ref_mem[q] = value;
   endtask

   task automatic verify_counter(input queue_addr_t q);
      reg_value_t data;
      host_access(1'b0, q, 32'h0, data);
      check_value($sformatf("host read of queue %0d", q), data, ref_mem[q]);
   endtask

   task automatic wait_updates_done();
      int n;
      n = 0;
      while ((exp_a.size() != 0 || exp_b.size() != 0) && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (exp_a.size() != 0 || exp_b.size() != 0) begin
         stop_run("Timed out waiting for a pending update to complete");
      end
   endtask

   // B starts b_lag cycles after A, an optional read goes out in cycle rd_cyc
   task automatic run_step(input logic do_a, input queue_addr_t qa, input write_value_t amt_a,
                           input logic do_b, input queue_addr_t qb, input write_value_t amt_b,
                           input int b_lag, input int rd_cyc, input logic rd_on_b,
                           input queue_addr_t qr);
      int   cyc;
      logic merged;
      merged = do_a && do_b && (b_lag == 0) && (qa == qb);
      for (cyc = 0; cyc < 3; cyc++) begin
         @(negedge clk);
         wr_a = 1'b0;
         wr_b = 1'b0;
         rd_a = 1'b0;
         rd_b = 1'b0;
         if (do_a && cyc == 0) begin
            wr_a      = 1'b1;
            wr_addr_a = qa;
            wr_data_a = amt_a;
            // Joint update lands on channel A only
            if (merged) begin
               ref_mem[qa] = add_ref(ref_mem[qa], amt_a, amt_b);
            end else begin
               ref_mem[qa] = add_ref(ref_mem[qa], amt_a, 16'h0);
            end
            exp_a.push_back(ref_mem[qa]);
         end
         if (do_b && cyc == b_lag) begin
            wr_b      = 1'b1;
            wr_addr_b = qb;
            wr_data_b = amt_b;
            if (!merged) begin
               ref_mem[qb] = add_ref(ref_mem[qb], amt_b, 16'h0);
               exp_b.push_back(ref_mem[qb]);
            end
         end
         if (cyc == rd_cyc) begin
            if (rd_on_b) begin
               rd_b      = 1'b1;
               rd_addr_b = qr;
               rd_exp_b.push_back(ref_mem[qr]);
            end else begin
               rd_a      = 1'b1;
               rd_addr_a = qr;
               rd_exp_a.push_back(ref_mem[qr]);
            end
         end
      end
      @(negedge clk);
      wr_a = 1'b0;
      wr_b = 1'b0;
      rd_a = 1'b0;
      rd_b = 1'b0;
      wait_updates_done();
      // Keeps each channel to one access per eight cycles
      repeat (8) @(negedge clk);
   endtask

   task automatic random_step();
      logic [31:0] rnd;
      logic [31:0] amounts;
      logic        do_a;
      logic        do_b;
      logic        rd_on_b;
      queue_addr_t qa;
      queue_addr_t qb;
      queue_addr_t qr;
      int          b_lag;
      int          rd_cyc;
      rnd     = $random(seed);
      amounts = $random(seed);
      if (rnd[2:0] == 3'd0) begin
         set_counter(rnd[5:3], reg_value_t'($random(seed)));
      end else begin
         do_a    = rnd[3];
         do_b    = rnd[4];
         qa      = rnd[7:5];
         qb      = rnd[11] ? rnd[7:5] : rnd[10:8];
         b_lag   = rnd[12] ? 1 : 0;
         rd_cyc  = -1;
         rd_on_b = 1'b0;
         qr      = rnd[18:16];
         // Read on the idle channel, never of the queue being updated
         if (rnd[13] && !(do_a && do_b)) begin
            rd_cyc  = (rnd[15:14] == 2'd3) ? 0 : int'(rnd[15:14]);
            rd_on_b = do_a;
            if (do_a && qr == qa) begin
               qr = qr + 3'd1;
            end
            if (do_b && qr == qb) begin
               qr = qr + 3'd1;
            end
         end
         run_step(do_a, qa, amounts[15:0], do_b, qb, amounts[31:16], b_lag, rd_cyc,
                  rd_on_b, qr);
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial begin
      seed        = 32'h0b0734e0;
      reset       = 1'b1;
      rd_a        = 1'b0;
      rd_b        = 1'b0;
      rd_addr_a   = 3'd0;
      rd_addr_b   = 3'd0;
      wr_a        = 1'b0;
      wr_b        = 1'b0;
      wr_addr_a   = 3'd0;
      wr_addr_b   = 3'd0;
      wr_data_a   = 16'h0;
      wr_data_b   = 16'h0;
      reg_req     = 1'b0;
      reg_wr      = 1'b0;
      reg_addr    = 3'd0;
      reg_wr_data = 32'h0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Clear every counter through the host port, then read back
      for (int q = 0; q < NUM_QUEUES; q++) begin
         set_counter(queue_addr_t'(q), 32'h0);
      end
      for (int q = 0; q < NUM_QUEUES; q++) begin
         verify_counter(queue_addr_t'(q));
      end

      // Independent updates on both channels
      run_step(1'b1, 3'd3, 16'h1234, 1'b1, 3'd5, 16'habcd, 0, -1, 1'b0, 3'd0);
      run_step(1'b1, 3'd0, 16'hffff, 1'b0, 3'd0, 16'h0, 0, -1, 1'b0, 3'd0);
      run_step(1'b0, 3'd0, 16'h0, 1'b1, 3'd3, 16'h0101, 0, -1, 1'b0, 3'd0);
      verify_counter(3'd3);
      verify_counter(3'd5);
      verify_counter(3'd0);

      // Same queue on both channels in one cycle, also across the wrap
      run_step(1'b1, 3'd2, 16'h8000, 1'b1, 3'd2, 16'h9000, 0, -1, 1'b0, 3'd0);
      verify_counter(3'd2);
      set_counter(3'd2, 32'hffff_fff0);
      run_step(1'b1, 3'd2, 16'h0010, 1'b1, 3'd2, 16'h0005, 0, -1, 1'b0, 3'd0);
      verify_counter(3'd2);

      // B follows A on one queue a cycle later
      run_step(1'b1, 3'd6, 16'h0400, 1'b1, 3'd6, 16'h0033, 1, -1, 1'b0, 3'd0);
      verify_counter(3'd6);

      // Reads at each point of a pending update
      for (int ofs = 0; ofs < 3; ofs++) begin
         run_step(1'b1, 3'd1, 16'h0077, 1'b0, 3'd0, 16'h0, 0, ofs, 1'b1, 3'd5);
         run_step(1'b0, 3'd0, 16'h0, 1'b1, 3'd7, 16'h0150, 0, ofs, 1'b0, 3'd3);
      end
      for (int q = 0; q < NUM_QUEUES; q++) begin
         verify_counter(queue_addr_t'(q));
      end

      // Random mix of updates, reads and host writes
      for (int i = 0; i < 40; i++) begin
         random_step();
      end
      for (int q = 0; q < NUM_QUEUES; q++) begin
         verify_counter(queue_addr_t'(q));
      end

      $display("All tests passed");
      $finish;
   end

endmodule
